//--- design/cpu_pkg.sv
package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [1:0]  reg_idx_t;

    //////////////////////////////////////////////////
    // Instruction fields

    localparam int opcode_hi = 15;
    localparam int opcode_lo = 12;
    localparam int rs_hi     = 11;
    localparam int rs_lo     = 10;
    localparam int rt_hi     = 9;
    localparam int rt_lo     = 8;
    localparam int rd_hi     = 7;
    localparam int rd_lo     = 6;
    localparam int funct_hi  = 5;
    localparam int funct_lo  = 0;
    localparam int imm_hi    = 7;
    localparam int imm_lo    = 0;
    localparam int target_hi = 11;
    localparam int target_lo = 0;

    localparam word_t nop_word = 16'hf03f;  // RTYPE, unused funct

    //////////////////////////////////////////////////
    // Encodings

    typedef enum logic [3:0] {
        op_bne   = 4'd0,
        op_beq   = 4'd1,
        op_adi   = 4'd4,
        op_ori   = 4'd5,
        op_lhi   = 4'd6,
        op_lwd   = 4'd7,
        op_swd   = 4'd8,
        op_jmp   = 4'd9,
        op_rtype = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        fn_add = 6'd0,
        fn_sub = 6'd1,
        fn_and = 6'd2,
        fn_orr = 6'd3,
        fn_wwd = 6'd28,
        fn_hlt = 6'd29
    } funct_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_lhi     // Immediate into upper byte
    } alu_op_e;

endpackage

//--- design/pipe_if.sv
`timescale 1ns/1ps

// Decoded instruction, ID/EX register
interface id_ex_if
    import cpu_pkg::*;
();
    logic     valid;
    alu_op_e  alu_op;
    logic     alu_src_imm;
    word_t    a;
    word_t    b;
    word_t    imm;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t dest;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     is_branch_ne;
    logic     is_branch_eq;
    logic     is_jump;
    logic     wwd;
    logic     halt;
    word_t    pc;

    modport source (
        output valid, alu_op, alu_src_imm, a, b, imm, rs, rt, dest,
        output reg_write, mem_read, mem_write, is_branch_ne, is_branch_eq,
        output is_jump, wwd, halt, pc
    );

    modport sink (
        input valid, alu_op, alu_src_imm, a, b, imm, rs, rt, dest,
        input reg_write, mem_read, mem_write, is_branch_ne, is_branch_eq,
        input is_jump, wwd, halt, pc
    );
endinterface

// Pending register write of a stage
interface result_if
    import cpu_pkg::*;
();
    logic     valid;
    logic     reg_write;
    reg_idx_t dest;
    word_t    value;
    logic     mem_read;

    modport source (output valid, reg_write, dest, value, mem_read);
    modport sink   (input valid, reg_write, dest, value, mem_read);
endinterface

//--- design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  stall,
    input  logic  redirect,
    input  logic  halt_seen,
    input  word_t redirect_pc,
    input  word_t inst_data,
    output word_t inst_addr,
    output word_t if_inst,
    output word_t if_pc,
    output logic  if_valid
);

    word_t pc;

    assign inst_addr = pc;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc       <= '0;
            if_inst  <= nop_word;
            if_pc    <= '0;
            if_valid <= 1'b0;
        end else if (redirect) begin
            pc       <= redirect_pc;  // Taken branch or jump
            if_inst  <= nop_word;
            if_valid <= 1'b0;
        end else if (stall) begin
            pc <= pc;                 // Load-use, hold IF/ID
        end else if (halt_seen) begin
            if_inst  <= nop_word;
            if_valid <= 1'b0;
        end else begin
            pc       <= pc + 16'd1;
            if_inst  <= inst_data;
            if_pc    <= pc;
            if_valid <= 1'b1;
        end
    end

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    input  word_t   if_inst,
    input  word_t   if_pc,
    input  logic    if_valid,
    input  logic    flush,
    result_if.sink  mem_wb_res,
    id_ex_if.source id_ex,
    output logic    stall,
    output logic    halt_seen
);

    opcode_e  opcode;
    funct_e   funct;
    reg_idx_t rs, rt, rd;
    word_t    imm_sext, imm_zext, jump_target;
    word_t    regs [4];
    word_t    rs_val, rt_val;
    logic     wb_hit;
    logic     halt_hold;

    alu_op_e  dec_alu_op;
    reg_idx_t dec_dest;
    word_t    dec_imm;
    logic     dec_src_imm, dec_reg_write, dec_mem_read, dec_mem_write;
    logic     dec_bne, dec_beq, dec_jump, dec_wwd, dec_halt;
    logic     uses_rs, uses_rt;

    assign opcode = opcode_e'(if_inst[opcode_hi:opcode_lo]);
    assign funct  = funct_e'(if_inst[funct_hi:funct_lo]);
    assign rs     = if_inst[rs_hi:rs_lo];
    assign rt     = if_inst[rt_hi:rt_lo];
    assign rd     = if_inst[rd_hi:rd_lo];

    assign imm_sext    = {{8{if_inst[imm_hi]}}, if_inst[imm_hi:imm_lo]};
    assign imm_zext    = {8'h00, if_inst[imm_hi:imm_lo]};
    assign jump_target = {if_pc[15:12], if_inst[target_hi:target_lo]};

    //////////////////////////////////////////////////
    // Control decode

    always_comb begin
        dec_alu_op    = alu_add;
        dec_dest      = rt;
        dec_imm       = imm_sext;
        dec_src_imm   = 1'b0;
        dec_reg_write = 1'b0;
        dec_mem_read  = 1'b0;
        dec_mem_write = 1'b0;
        dec_bne       = 1'b0;
        dec_beq       = 1'b0;
        dec_jump      = 1'b0;
        dec_wwd       = 1'b0;
        dec_halt      = 1'b0;
        uses_rs       = 1'b0;
        uses_rt       = 1'b0;
        case (opcode)
            op_bne: begin
                dec_bne = 1'b1;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
            end
            op_beq: begin
                dec_beq = 1'b1;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
            end
            op_adi, op_lwd: begin
                dec_src_imm   = 1'b1;
                dec_reg_write = 1'b1;
                dec_mem_read  = (opcode == op_lwd);
                uses_rs       = 1'b1;
            end
            op_ori: begin
                dec_alu_op    = alu_or;
                dec_imm       = imm_zext;
                dec_src_imm   = 1'b1;
                dec_reg_write = 1'b1;
                uses_rs       = 1'b1;
            end
            op_lhi: begin
                dec_alu_op    = alu_lhi;
                dec_src_imm   = 1'b1;
                dec_reg_write = 1'b1;
            end
            op_swd: begin
                dec_src_imm   = 1'b1;
                dec_mem_write = 1'b1;
                uses_rs       = 1'b1;
                uses_rt       = 1'b1;     // Store data
            end
            op_jmp: begin
                dec_jump = 1'b1;
                dec_imm  = jump_target;
            end
            op_rtype: begin
                dec_dest = rd;
                case (funct)
                    fn_add, fn_sub, fn_and, fn_orr: begin
                        dec_reg_write = 1'b1;
                        uses_rs       = 1'b1;
                        uses_rt       = 1'b1;
                        case (funct)
                            fn_sub:  dec_alu_op = alu_sub;
                            fn_and:  dec_alu_op = alu_and;
                            fn_orr:  dec_alu_op = alu_or;
                            default: dec_alu_op = alu_add;
                        endcase
                    end
                    fn_wwd: begin
                        dec_wwd = 1'b1;
                        uses_rs = 1'b1;
                    end
                    fn_hlt:  dec_halt = 1'b1;
                    default: dec_halt = 1'b0;
                endcase
            end
            default: dec_halt = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // Register file, write-through from writeback

    assign wb_hit = mem_wb_res.valid && mem_wb_res.reg_write;
    assign rs_val = (wb_hit && mem_wb_res.dest == rs) ? mem_wb_res.value : regs[rs];
    assign rt_val = (wb_hit && mem_wb_res.dest == rt) ? mem_wb_res.value : regs[rt];

    always_ff @(posedge clk) begin
        if (wb_hit) begin
            regs[mem_wb_res.dest] <= mem_wb_res.value;
        end
    end

    // Load in ID/EX feeding this instruction
    assign stall = if_valid && id_ex.valid && id_ex.mem_read &&
                   ((uses_rs && id_ex.dest == rs) || (uses_rt && id_ex.dest == rt));

    assign halt_seen = halt_hold || (if_valid && dec_halt);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            halt_hold <= 1'b0;
        end else if (if_valid && dec_halt && !flush) begin
            halt_hold <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // ID/EX register

    always_ff @(posedge clk) begin
        if (reset_n || stall || flush) begin
            id_ex.valid        <= 1'b0;   // Bubble
            id_ex.reg_write    <= 1'b0;
            id_ex.mem_read     <= 1'b0;
            id_ex.mem_write    <= 1'b0;
            id_ex.is_branch_ne <= 1'b0;
            id_ex.is_branch_eq <= 1'b0;
            id_ex.is_jump      <= 1'b0;
            id_ex.wwd          <= 1'b0;
            id_ex.halt         <= 1'b0;
        end else begin
            id_ex.valid        <= if_valid;
            id_ex.reg_write    <= if_valid && dec_reg_write;
            id_ex.mem_read     <= if_valid && dec_mem_read;
            id_ex.mem_write    <= if_valid && dec_mem_write;
            id_ex.is_branch_ne <= if_valid && dec_bne;
            id_ex.is_branch_eq <= if_valid && dec_beq;
            id_ex.is_jump      <= if_valid && dec_jump;
            id_ex.wwd          <= if_valid && dec_wwd;
            id_ex.halt         <= if_valid && dec_halt;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.alu_op      <= dec_alu_op;
        id_ex.alu_src_imm <= dec_src_imm;
        id_ex.a           <= rs_val;
        id_ex.b           <= rt_val;
        id_ex.imm         <= dec_imm;
        id_ex.rs          <= rs;
        id_ex.rt          <= rt;
        id_ex.dest        <= dec_dest;
        id_ex.pc          <= if_pc;
    end

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    id_ex_if.sink    id_ex,
    result_if.sink   mem_wb_res,
    result_if.source ex_mem_res,
    output logic     redirect,
    output word_t    redirect_pc,
    output word_t    ex_wdata,
    output logic     ex_mem_write,
    output logic     ex_wwd,
    output logic     ex_halt
);

    word_t opnd_a, opnd_b;
    word_t alu_b, alu_out;
    logic  taken;

    // Youngest pending write wins
    function automatic word_t fwd_value(input reg_idx_t src, input word_t reg_val);
        if (ex_mem_res.valid && ex_mem_res.reg_write && !ex_mem_res.mem_read &&
            ex_mem_res.dest == src) begin
            return ex_mem_res.value;
        end
        if (mem_wb_res.valid && mem_wb_res.reg_write && mem_wb_res.dest == src) begin
            return mem_wb_res.value;
        end
        return reg_val;
    endfunction

    //////////////////////////////////////////////////
    // Operands and ALU

    always_comb begin
        opnd_a = fwd_value(id_ex.rs, id_ex.a);
        opnd_b = fwd_value(id_ex.rt, id_ex.b);
    end

    assign alu_b = id_ex.alu_src_imm ? id_ex.imm : opnd_b;

    always_comb begin
        case (id_ex.alu_op)
            alu_sub: alu_out = opnd_a - alu_b;
            alu_and: alu_out = opnd_a & alu_b;
            alu_or:  alu_out = opnd_a | alu_b;
            alu_lhi: alu_out = {alu_b[7:0], 8'h00};
            default: alu_out = opnd_a + alu_b;
        endcase
    end

    //////////////////////////////////////////////////
    // Branch and jump resolution

    assign taken = (id_ex.is_branch_ne && opnd_a != opnd_b) ||
                   (id_ex.is_branch_eq && opnd_a == opnd_b);

    assign redirect    = id_ex.valid && (taken || id_ex.is_jump);
    assign redirect_pc = id_ex.is_jump ? id_ex.imm : id_ex.pc + 16'd1 + id_ex.imm;

    //////////////////////////////////////////////////
    // EX/MEM register

    always_ff @(posedge clk) begin
        if (reset_n) begin
            ex_mem_res.valid     <= 1'b0;
            ex_mem_res.reg_write <= 1'b0;
            ex_mem_res.mem_read  <= 1'b0;
            ex_mem_write         <= 1'b0;
            ex_wwd               <= 1'b0;
            ex_halt              <= 1'b0;
        end else begin
            ex_mem_res.valid     <= id_ex.valid;
            ex_mem_res.reg_write <= id_ex.reg_write;
            ex_mem_res.mem_read  <= id_ex.mem_read;
            ex_mem_write         <= id_ex.mem_write;
            ex_wwd               <= id_ex.wwd;
            ex_halt              <= id_ex.halt;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem_res.dest  <= id_ex.dest;
        ex_mem_res.value <= id_ex.wwd ? opnd_a : alu_out;  // WWD carries rs
        ex_wdata         <= opnd_b;
    end

endmodule

//--- design/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    result_if.sink   ex_mem_res,
    input  word_t    ex_wdata,
    input  logic     ex_mem_write,
    input  logic     ex_wwd,
    input  logic     ex_halt,
    input  word_t    data_rdata,
    result_if.source mem_wb_res,
    output word_t    data_addr,
    output word_t    data_wdata,
    output logic     data_read,
    output logic     data_write,
    output word_t    num_inst,
    output word_t    output_port,
    output logic     is_halted
);

    word_t wb_value;

    // Data port straight from EX/MEM
    assign data_addr  = ex_mem_res.value;
    assign data_wdata = ex_wdata;
    assign data_read  = ex_mem_res.valid && ex_mem_res.mem_read;
    assign data_write = ex_mem_res.valid && ex_mem_write;

    assign wb_value = ex_mem_res.mem_read ? data_rdata : ex_mem_res.value;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            mem_wb_res.valid     <= 1'b0;
            mem_wb_res.reg_write <= 1'b0;
            mem_wb_res.mem_read  <= 1'b0;
            num_inst             <= '0;
            output_port          <= '0;
            is_halted            <= 1'b0;
        end else begin
            mem_wb_res.valid     <= ex_mem_res.valid;
            mem_wb_res.reg_write <= ex_mem_res.reg_write;
            mem_wb_res.mem_read  <= ex_mem_res.mem_read;
            if (ex_mem_res.valid) begin
                num_inst <= num_inst + 16'd1;   // Retired count
            end
            if (ex_mem_res.valid && ex_wwd) begin
                output_port <= ex_mem_res.value;
            end
            if (ex_mem_res.valid && ex_halt) begin
                is_halted <= 1'b1;              // Sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        mem_wb_res.dest  <= ex_mem_res.dest;
        mem_wb_res.value <= wb_value;
    end

endmodule

//--- design/cpu_core.sv
`timescale 1ns/1ps

module cpu_core
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    output word_t inst_addr,
    input  word_t inst_data,
    output word_t data_addr,
    output logic  data_read,
    output logic  data_write,
    output word_t data_wdata,
    input  word_t data_rdata,
    output word_t num_inst,
    output word_t output_port,
    output logic  is_halted
);

    word_t if_inst;
    word_t if_pc;
    logic  if_valid;
    logic  stall;
    logic  halt_seen;
    logic  redirect;
    word_t redirect_pc;
    word_t ex_wdata;
    logic  ex_mem_write;
    logic  ex_wwd;
    logic  ex_halt;

    id_ex_if  id_ex ();
    result_if ex_mem_res ();
    result_if mem_wb_res ();

    fetch_unit fetch_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .stall       (stall),
        .redirect    (redirect),
        .halt_seen   (halt_seen),
        .redirect_pc (redirect_pc),
        .inst_data   (inst_data),
        .inst_addr   (inst_addr),
        .if_inst     (if_inst),
        .if_pc       (if_pc),
        .if_valid    (if_valid)
    );

    decode_stage decode_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .if_inst    (if_inst),
        .if_pc      (if_pc),
        .if_valid   (if_valid),
        .flush      (redirect),
        .mem_wb_res (mem_wb_res.sink),
        .id_ex      (id_ex.source),
        .stall      (stall),
        .halt_seen  (halt_seen)
    );

    execute_stage execute_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .id_ex        (id_ex.sink),
        .mem_wb_res   (mem_wb_res.sink),
        .ex_mem_res   (ex_mem_res.source),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .ex_wdata     (ex_wdata),
        .ex_mem_write (ex_mem_write),
        .ex_wwd       (ex_wwd),
        .ex_halt      (ex_halt)
    );

    mem_wb_stage mem_wb_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .ex_mem_res   (ex_mem_res.sink),
        .ex_wdata     (ex_wdata),
        .ex_mem_write (ex_mem_write),
        .ex_wwd       (ex_wwd),
        .ex_halt      (ex_halt),
        .data_rdata   (data_rdata),
        .mem_wb_res   (mem_wb_res.source),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_read    (data_read),
        .data_write   (data_write),
        .num_inst     (num_inst),
        .output_port  (output_port),
        .is_halted    (is_halted)
    );

endmodule

//--- test/cpu_assertions.sv
`timescale 1ns/1ps

module cpu_assertions (
    input logic clk,
    input logic reset_n,
    input logic stall,
    input logic redirect,
    input logic if_valid,
    input logic id_valid,
    input logic ex_valid
);

    // Load in ID/EX and branch in ID/EX exclude each other
    assert property (@(posedge clk) disable iff (reset_n) !(stall && redirect))
        else $error("stall and redirect are high in the same cycle");

    // Flushed slot travels on as a bubble
    assert property (@(posedge clk) disable iff (reset_n)
        redirect |=> !id_valid ##1 !ex_valid)
        else $error("instruction after a redirect was not flushed");

    //////////////////////////////////////////////////
    // Reset release

    assert property (@(posedge clk) $fell(reset_n) |-> !if_valid && !id_valid && !ex_valid)
        else $error("valid bit set when reset was released");

    assert property (@(posedge clk) $fell(reset_n) |=> !id_valid ##1 !ex_valid)
        else $error("valid bit set before the first fetch reached it");

endmodule

bind cpu_core cpu_assertions assert_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .stall    (stall),
    .redirect (redirect),
    .if_valid (if_valid),
    .id_valid (id_ex.valid),
    .ex_valid (ex_mem_res.valid)
);

//--- test/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int reset_cycles   = 10;
    localparam int prog_limit     = 80;
    localparam int num_tests      = 5;
    localparam int watchdog_limit = num_tests * (prog_limit + reset_cycles + 20) + 50;

    logic  clk;
    logic  reset_n;
    word_t inst_addr;
    word_t inst_data;
    word_t data_addr;
    word_t data_wdata;
    word_t data_rdata;
    logic  data_read;
    logic  data_write;
    word_t num_inst;
    word_t output_port;
    logic  is_halted;

    word_t imem [256];
    word_t dmem [256];

    word_t       out_log [$];
    word_t       exp_log [$];
    word_t       last_out;
    word_t       last_exp;
    int          prog_len;
    int          exp_count;
    int          errors;
    int          checks;
    int          cycle_count = 0;
    logic [31:0] lcg_state;

    cpu_core dut_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .inst_addr   (inst_addr),
        .inst_data   (inst_data),
        .data_addr   (data_addr),
        .data_read   (data_read),
        .data_write  (data_write),
        .data_wdata  (data_wdata),
        .data_rdata  (data_rdata),
        .num_inst    (num_inst),
        .output_port (output_port),
        .is_halted   (is_halted)
    );

    //////////////////////////////////////////////////
    // Memories, clock, output monitor, watchdog

    assign inst_data  = imem[inst_addr[7:0]];
    assign data_rdata = data_read ? dmem[data_addr[7:0]] : 'x;   // Valid only on a read

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (data_write) begin
            dmem[data_addr[7:0]] <= data_wdata;
        end
    end

    always @(posedge clk) begin
        if (!reset_n && output_port !== last_out) begin
            out_log.push_back(output_port);
            last_out = output_port;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= watchdog_limit) begin
            $display("TIMEOUT: run did not finish within %0d cycles", watchdog_limit);
            $display("sim failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Encoding and reference helpers

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t sext8(input logic [7:0] imm);
        return {{8{imm[7]}}, imm};
    endfunction

    function automatic word_t dmem_fill(input int addr);
        return {addr[7:0] ^ 8'h5a, addr[7:0]};
    endfunction

    function automatic word_t enc_r(input reg_idx_t rs, input reg_idx_t rt,
                                    input reg_idx_t rd, input funct_e fn);
        return {op_rtype, rs, rt, rd, fn};
    endfunction

    function automatic word_t enc_i(input opcode_e op, input reg_idx_t rs,
                                    input reg_idx_t rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_j(input logic [11:0] target);
        return {op_jmp, target};
    endfunction

    function automatic word_t enc_wwd(input reg_idx_t rs);
        return enc_r(rs, 2'd0, 2'd0, fn_wwd);
    endfunction

    function automatic word_t enc_hlt();
        return enc_r(2'd0, 2'd0, 2'd0, fn_hlt);
    endfunction

    task automatic rand_word(output word_t value);
        lcg_state = lcg_next(lcg_state);
        value = lcg_state[31:16];
    endtask

    //////////////////////////////////////////////////
    // Program building and running

    task automatic new_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = enc_hlt();        // Stray fetch stops the core
            dmem[i] = dmem_fill(i);
        end
        prog_len  = 0;
        exp_count = 0;
        last_exp  = '0;
        exp_log.delete();
    endtask

    task automatic emit(input word_t inst);
        imem[prog_len] = inst;
        prog_len++;
        exp_count++;
    endtask

    // Never retires
    task automatic emit_skipped(input word_t inst);
        imem[prog_len] = inst;
        prog_len++;
    endtask

    task automatic load_const(input reg_idx_t rd, input word_t value);
        emit(enc_i(op_lhi, 2'd0, rd, value[15:8]));
        emit(enc_i(op_ori, rd, rd, value[7:0]));
    endtask

    // Only changes of output_port are visible
    task automatic expect_out(input word_t value);
        if (value !== last_exp) begin
            exp_log.push_back(value);
            last_exp = value;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        reset_n = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #2;
        out_log.delete();
        last_out = '0;
        reset_n  = 1'b0;
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %b actual %b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_log(input string name);
        int n;
        n = (out_log.size() < exp_log.size()) ? out_log.size() : exp_log.size();
        check_word($sformatf("%s output count", name), word_t'(exp_log.size()),
                   word_t'(out_log.size()));
        for (int i = 0; i < n; i++) begin
            check_word($sformatf("%s output %0d", name, i), exp_log[i], out_log[i]);
        end
    endtask

    task automatic run_program(input string name);
        int waited;
        waited = 0;
        while (!is_halted && waited < prog_limit) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!is_halted) begin
            $display("ERROR %s: program did not halt within %0d cycles", name, prog_limit);
            errors++;
        end
        repeat (2) @(posedge clk);
        #2;
        compare_log(name);
        check_word($sformatf("%s num_inst", name), word_t'(exp_count), num_inst);
    endtask

    //////////////////////////////////////////////////
    // Directed tests

    task automatic test_arith();
        word_t va, vb, vc;
        word_t r0, r1, r2, r3;
        rand_word(va);
        rand_word(vb);
        rand_word(vc);
        new_program();
        r0 = {va[15:8], 8'h00} | {8'h00, va[7:0]};
        r1 = {vb[15:8], 8'h00} | {8'h00, vb[7:0]};
        load_const(2'd0, va);
        load_const(2'd1, vb);
        emit(enc_wwd(2'd0));
        expect_out(r0);
        emit(enc_wwd(2'd1));
        expect_out(r1);
        r2 = r0 + sext8(vc[7:0]);
        emit(enc_i(op_adi, 2'd0, 2'd2, vc[7:0]));
        r3 = r2 + r1;
        emit(enc_r(2'd2, 2'd1, 2'd3, fn_add));     // EX/MEM forward
        emit(enc_wwd(2'd2));
        expect_out(r2);
        emit(enc_wwd(2'd3));
        expect_out(r3);
        r2 = r3 - r0;
        emit(enc_r(2'd3, 2'd0, 2'd2, fn_sub));
        emit(enc_wwd(2'd2));
        expect_out(r2);
        r3 = r2 & r1;
        emit(enc_r(2'd2, 2'd1, 2'd3, fn_and));
        emit(enc_wwd(2'd3));
        expect_out(r3);
        r0 = r3 | r2;
        emit(enc_r(2'd3, 2'd2, 2'd0, fn_orr));
        emit(enc_wwd(2'd0));
        expect_out(r0);
        r1 = {vc[15:8], 8'h00};
        emit(enc_i(op_lhi, 2'd0, 2'd1, vc[15:8]));
        emit(enc_wwd(2'd1));
        expect_out(r1);
        emit(enc_hlt());
        apply_reset();
        run_program("arith");
    endtask

    task automatic test_load_store();
        word_t r0, r1, r2, r3;
        word_t st_addr, ld_addr;
        new_program();
        r0 = 16'h0040;
        r1 = 16'hc35e;
        st_addr = r0 + sext8(8'd3);
        ld_addr = r0 + sext8(8'hfe);
        load_const(2'd0, r0);
        load_const(2'd1, r1);
        emit(enc_i(op_swd, 2'd0, 2'd1, 8'd3));
        emit(enc_i(op_lwd, 2'd0, 2'd2, 8'd3));
        r2 = r1;
        emit(enc_wwd(2'd2));                        // Load-use stall
        expect_out(r2);
        emit(enc_i(op_lwd, 2'd0, 2'd3, 8'hfe));
        r3 = dmem_fill(ld_addr[7:0]);
        emit(enc_r(2'd3, 2'd2, 2'd0, fn_add));
        r0 = r3 + r2;
        emit(enc_wwd(2'd0));
        expect_out(r0);
        emit(enc_hlt());
        apply_reset();
        run_program("load_store");
        check_word("load_store stored word", r1, dmem[st_addr[7:0]]);
    endtask

    task automatic test_branches();
        word_t r0, r1, r2, r3;
        new_program();
        r0 = 16'h1234;
        r1 = 16'h1234;
        r2 = 16'h0f0f;
        r3 = 16'h00a5;
        load_const(2'd0, r0);
        load_const(2'd1, r1);
        load_const(2'd2, r2);
        emit(enc_i(op_beq, 2'd0, 2'd1, 8'd2));     // Taken
        emit_skipped(enc_wwd(2'd2));
        emit_skipped(enc_wwd(2'd3));
        emit(enc_wwd(2'd0));
        expect_out(r0);
        emit(enc_i(op_bne, 2'd0, 2'd1, 8'd1));     // Not taken
        emit(enc_wwd(2'd2));
        expect_out(r2);
        emit(enc_i(op_beq, 2'd0, 2'd2, 8'd1));     // Not taken
        emit(enc_wwd(2'd0));
        expect_out(r0);
        load_const(2'd3, r3);
        emit(enc_i(op_bne, 2'd2, 2'd3, 8'd2));     // Taken
        emit_skipped(enc_wwd(2'd2));
        emit_skipped(enc_wwd(2'd0));
        emit(enc_wwd(2'd3));
        expect_out(r3);
        emit(enc_j(12'(prog_len + 3)));
        emit_skipped(enc_wwd(2'd0));
        emit_skipped(enc_wwd(2'd1));
        emit(enc_wwd(2'd2));
        expect_out(r2);
        emit(enc_hlt());
        apply_reset();
        run_program("branches");
    endtask

    task automatic test_halt_count();
        word_t r0, r1;
        new_program();
        r0 = 16'h7700;
        r1 = r0 + sext8(8'd1);
        emit(enc_i(op_lhi, 2'd0, 2'd0, 8'h77));
        emit(enc_wwd(2'd0));
        expect_out(r0);
        emit(enc_i(op_adi, 2'd0, 2'd1, 8'd1));
        emit(enc_i(op_bne, 2'd0, 2'd1, 8'd1));     // Taken
        emit_skipped(enc_i(op_adi, 2'd1, 2'd1, 8'd5));
        emit(enc_wwd(2'd1));
        expect_out(r1);
        emit(enc_hlt());
        emit_skipped(enc_wwd(2'd0));                // Past HLT
        emit_skipped(enc_i(op_lhi, 2'd0, 2'd1, 8'h99));
        emit_skipped(enc_wwd(2'd1));
        apply_reset();
        run_program("halt_count");
        repeat (10) @(posedge clk);
        #2;
        check_bit("halt_count is_halted held", 1'b1, is_halted);
        check_word("halt_count num_inst held", word_t'(exp_count), num_inst);
        check_word("halt_count output_port held", r1, output_port);
        check_word("halt_count output count held", word_t'(exp_log.size()),
                   word_t'(out_log.size()));
    endtask

    task automatic test_reset();
        word_t r2, r3;
        new_program();
        r2 = 16'h3cc3;
        r3 = r2 + sext8(8'hff);
        load_const(2'd2, r2);
        emit(enc_wwd(2'd2));
        expect_out(r2);
        emit(enc_i(op_adi, 2'd2, 2'd3, 8'hff));
        emit(enc_wwd(2'd3));
        expect_out(r3);
        emit(enc_hlt());
        apply_reset();                              // Core was halted here
        check_word("reset num_inst", '0, num_inst);
        check_word("reset output_port", '0, output_port);
        check_bit("reset is_halted", 1'b0, is_halted);
        run_program("reset");
    endtask

    initial begin
        clk       = 1'b0;
        reset_n   = 1'b1;
        errors    = 0;
        checks    = 0;
        last_out  = '0;
        last_exp  = '0;
        prog_len  = 0;
        exp_count = 0;
        lcg_state = 32'h310d0e2b;
        test_arith();
        test_load_store();
        test_branches();
        test_halt_count();
        test_reset();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- flist.f
design/cpu_pkg.sv
design/pipe_if.sv
design/fetch_unit.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/cpu_core.sv
test/cpu_assertions.sv
test/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - files:
      - design/cpu_pkg.sv
      - design/pipe_if.sv
      - design/fetch_unit.sv
      - design/decode_stage.sv
      - design/execute_stage.sv
      - design/mem_wb_stage.sv
      - design/cpu_core.sv
  - target: test
    files:
      - test/cpu_assertions.sv
      - test/cpu_tb.sv
